//--- filelist.f
fifo_pkg.sv
reset_sync.sv
fifo_write_ctrl.sv
fifo_read_ctrl.sv
fifo_mem.sv
output_pipe.sv
axis_async_fifo.sv
axis_fifo_chk.sv
tb_axis_async_fifo.sv

//--- Makefile
# Verilator build for the dual-clock stream FIFO testbench

TOP := tb_axis_async_fifo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log; grep -q '^STATUS: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_axis_async_fifo.sv
// expects the DUT defaults ADDR_WIDTH 4 and PIPELINE_OUTPUT 2; stops at the first failed check
`timescale 1ns/1ps

module tb_axis_async_fifo;

    localparam int ADDR_WIDTH      = 4;
    localparam int PIPELINE_OUTPUT = 2;
    localparam int CAPACITY        = (2 ** ADDR_WIDTH) + PIPELINE_OUTPUT;
    localparam int RANDOM_WORDS    = 400;
    localparam int WAIT_LIMIT      = 20000;
    localparam int FULL_HOLD       = 32;
    localparam int IDLE_HOLD       = 16;

    // stimulus phases
    localparam int PH_IDLE  = 0;
    localparam int PH_RAND  = 1;
    localparam int PH_FILL  = 2;
    localparam int PH_DRAIN = 3;

    logic            async_rst;
    logic            s_clk = 1'b0;
    logic            m_clk = 1'b0;
    fifo_pkg::data_t s_tdata;
    logic            s_tvalid;
    logic            s_tready;
    logic            s_tlast;
    fifo_pkg::user_t s_tuser;
    fifo_pkg::data_t m_tdata;
    logic            m_tvalid;
    logic            m_tready;
    logic            m_tlast;
    fifo_pkg::user_t m_tuser;

    fifo_pkg::word_t model_q [$];
    fifo_pkg::word_t rd_expect;
    int              phase;
    int              wr_count;
    int              fill_base;
    int              low_run;
    int              cycles;
    bit              wr_took;
    bit              run_done;
    logic [31:0]     wr_state = 32'd22812;
    logic [31:0]     rd_state;

    axis_async_fifo #(
        .ADDR_WIDTH      (ADDR_WIDTH),
        .PIPELINE_OUTPUT (PIPELINE_OUTPUT)
    ) DUT (
        .async_rst (async_rst),
        .s_clk     (s_clk),
        .s_tdata   (s_tdata),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .s_tlast   (s_tlast),
        .s_tuser   (s_tuser),
        .m_clk     (m_clk),
        .m_tdata   (m_tdata),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .m_tlast   (m_tlast),
        .m_tuser   (m_tuser)
    );

    initial begin
        forever #4 m_clk = ~m_clk;
    end

    initial begin
        forever #5 s_clk = ~s_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure();
        run_done = 1'b1;
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic check_data(input string name, input fifo_pkg::data_t got,
                              input fifo_pkg::data_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_user(input string name, input fifo_pkg::user_t got,
                              input fifo_pkg::user_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // pending write taken first, then the read side runs dry
    task automatic wait_drained();
        int count = 0;
        do begin
            @(posedge s_clk);
            count++;
            if (count > WAIT_LIMIT) begin
                $display("timeout: the pending write was never accepted");
                stop_with_failure();
            end
        end while (s_tvalid);
        count = 0;
        do begin
            @(negedge m_clk);
            count++;
            if (count > WAIT_LIMIT) begin
                $display("timeout: the FIFO did not empty, %0d words missing", model_q.size());
                stop_with_failure();
            end
        end while (model_q.size() != 0 || m_tvalid);
    endtask

    // a word that is offered stays until taken
    always @(negedge s_clk) begin
        if (!(s_tvalid && !wr_took)) begin
            wr_state = lcg_next(wr_state);
            s_tdata  = wr_state[23:16];
            s_tlast  = wr_state[29];
            s_tuser  = wr_state[28];
            case (phase)
                PH_RAND: s_tvalid = (wr_state[31:30] != 2'b00);
                PH_FILL: s_tvalid = 1'b1;
                default: s_tvalid = 1'b0;
            endcase
        end
    end

    always @(negedge m_clk) begin
        rd_state = lcg_next(rd_state);
        case (phase)
            PH_RAND:  m_tready = rd_state[30];
            PH_DRAIN: m_tready = 1'b1;
            default:  m_tready = 1'b0;
        endcase
    end

    // write side model, user on top, then last, then data
    always @(posedge s_clk) begin
        wr_took = s_tvalid && s_tready;
        if (wr_took) begin
            model_q.push_back({s_tuser, s_tlast, s_tdata});
            wr_count++;
        end
    end

    always @(posedge m_clk) begin
        if (m_tvalid && m_tready) begin
            if (model_q.size() == 0) begin
                $display("read side delivered a word that was never written, time %0t", $time);
                stop_with_failure();
            end else begin
                rd_expect = model_q.pop_front();
                check_data("m_tdata", m_tdata, rd_expect[fifo_pkg::DATA_WIDTH-1:0]);
                check_bit("m_tlast", m_tlast, rd_expect[fifo_pkg::DATA_WIDTH]);
                check_user("m_tuser", m_tuser,
                           rd_expect[fifo_pkg::DATA_WIDTH+1 +: fifo_pkg::USER_WIDTH]);
            end
        end
    end

    initial begin
        async_rst = 1'b1;
        s_tdata   = '0;
        s_tvalid  = 1'b0;
        s_tlast   = 1'b0;
        s_tuser   = '0;
        m_tready  = 1'b0;
        phase     = PH_IDLE;
        wr_count  = 0;
        wr_took   = 1'b0;
        run_done  = 1'b0;
        rd_state  = lcg_next(32'd22812);

        repeat (2) begin
            @(negedge m_clk);
            check_bit("s_tready", s_tready, 1'b0);
            check_bit("m_tvalid", m_tvalid, 1'b0);
        end
        async_rst = 1'b0;
        // synchronizer stages still holding both sides
        repeat (3) begin
            @(negedge m_clk);
            check_bit("s_tready", s_tready, 1'b0);
            check_bit("m_tvalid", m_tvalid, 1'b0);
        end

        @(posedge s_clk);
        phase = PH_RAND;
        cycles = 0;
        while (wr_count < RANDOM_WORDS) begin
            @(negedge s_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: only %0d random words were accepted", wr_count);
                stop_with_failure();
            end
        end
        @(posedge s_clk);
        phase = PH_DRAIN;
        wait_drained();

        // fill with the reader stalled
        fill_base = wr_count;
        @(posedge s_clk);
        phase   = PH_FILL;
        low_run = 0;
        cycles  = 0;
        while (low_run < FULL_HOLD) begin
            @(negedge s_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: s_tready never stayed low with the reader stalled");
                stop_with_failure();
            end
            if (s_tready) begin
                low_run = 0;
            end else begin
                low_run++;
            end
        end
        check_count("accepted_words", wr_count - fill_base, CAPACITY);

        @(posedge s_clk);
        phase = PH_DRAIN;
        wait_drained();

        // read side must stay quiet once the last word is out
        repeat (IDLE_HOLD) begin
            @(negedge m_clk);
            check_bit("m_tvalid", m_tvalid, 1'b0);
        end
        run_done = 1'b1;
        $display("STATUS: PASS");
        $finish;
    end

    // run cut short before the sequence finished
    final begin
        if (!run_done) begin
            $display("STATUS: FAIL");
        end
    end

endmodule

//--- axis_fifo_chk.sv
// bound into axis_async_fifo; the assertions only act when the simulator runs them
`timescale 1ns/1ps

module axis_fifo_chk (
    input logic            async_rst,
    input logic            s_clk,
    input logic            m_clk,
    input logic            s_rst,
    input logic            m_rst,
    input logic            s_tready,
    input logic            m_tvalid,
    input logic            m_tready,
    input fifo_pkg::data_t m_tdata,
    input logic            m_tlast,
    input fifo_pkg::user_t m_tuser
);

    // raw reset reaches both domains at once
    a_reset_both: assert property (@(posedge s_clk) async_rst |-> s_rst && m_rst)
        else $error("async_rst is high but a domain reset is low");

    // closed while reset is held and for three sync edges after release
    a_no_ready_in_reset: assert property (@(posedge s_clk)
        async_rst || $past(async_rst) || $past(async_rst, 2) || $past(async_rst, 3)
        |-> !s_tready)
        else $error("s_tready high during reset or its synchronizer cycles");

    a_no_valid_in_reset: assert property (@(posedge m_clk)
        async_rst || $past(async_rst) || $past(async_rst, 2) || $past(async_rst, 3)
        |-> !m_tvalid)
        else $error("m_tvalid high during reset or its synchronizer cycles");

    // stalled output word must not move
    a_hold_stalled: assert property (@(posedge m_clk) disable iff (m_rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
                                  && $stable(m_tuser))
        else $error("read side word changed while stalled");

endmodule

bind axis_async_fifo axis_fifo_chk u_chk (
    .async_rst (async_rst),
    .s_clk     (s_clk),
    .m_clk     (m_clk),
    .s_rst     (s_rst),
    .m_rst     (m_rst),
    .s_tready  (s_tready),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast),
    .m_tuser   (m_tuser)
);

//--- axis_async_fifo.sv
// cycle mode only; holds 2**ADDR_WIDTH words plus PIPELINE_OUTPUT in the output stages
`timescale 1ns/1ps

module axis_async_fifo #(
    parameter int ADDR_WIDTH      = 4,
    parameter int PIPELINE_OUTPUT = 2
) (
    input  logic            async_rst,

    // write side
    input  logic            s_clk,
    input  fifo_pkg::data_t s_tdata,
    input  logic            s_tvalid,
    output logic            s_tready,
    input  logic            s_tlast,
    input  fifo_pkg::user_t s_tuser,

    // read side
    input  logic            m_clk,
    output fifo_pkg::data_t m_tdata,
    output logic            m_tvalid,
    input  logic            m_tready,
    output logic            m_tlast,
    output fifo_pkg::user_t m_tuser
);

    logic                  s_rst;
    logic                  m_rst;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    fifo_pkg::word_t       wr_word;
    logic [ADDR_WIDTH:0]   wr_ptr_gray;
    logic [ADDR_WIDTH:0]   rd_ptr_gray;
    logic [ADDR_WIDTH-1:0] rd_addr;
    fifo_pkg::word_t       rd_word;
    logic                  pop;
    logic                  accept;

    reset_sync u_reset_sync (
        .async_rst (async_rst),
        .s_clk     (s_clk),
        .m_clk     (m_clk),
        .s_rst     (s_rst),
        .m_rst     (m_rst)
    );

    fifo_write_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_write_ctrl (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .s_tdata     (s_tdata),
        .s_tvalid    (s_tvalid),
        .s_tlast     (s_tlast),
        .s_tuser     (s_tuser),
        .rd_ptr_gray (rd_ptr_gray),
        .s_tready    (s_tready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_word     (wr_word),
        .wr_ptr_gray (wr_ptr_gray)
    );

    fifo_read_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_read_ctrl (
        .m_clk       (m_clk),
        .m_rst       (m_rst),
        .accept      (accept),
        .wr_ptr_gray (wr_ptr_gray),
        .pop         (pop),
        .rd_addr     (rd_addr),
        .rd_ptr_gray (rd_ptr_gray)
    );

    fifo_mem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem (
        .s_clk   (s_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_word (wr_word),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    output_pipe #(
        .PIPELINE_OUTPUT (PIPELINE_OUTPUT)
    ) u_output_pipe (
        .m_clk    (m_clk),
        .m_rst    (m_rst),
        .pop      (pop),
        .rd_word  (rd_word),
        .m_tready (m_tready),
        .accept   (accept),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser)
    );

endmodule

//--- output_pipe.sv
// PIPELINE_OUTPUT must be at least 1; outputs stay stable while m_tvalid is high and m_tready low
`timescale 1ns/1ps

module output_pipe #(
    parameter int PIPELINE_OUTPUT = 2
) (
    input  logic            m_clk,
    input  logic            m_rst,
    input  logic            pop,
    input  fifo_pkg::word_t rd_word,
    input  logic            m_tready,
    output logic            accept,
    output fifo_pkg::data_t m_tdata,
    output logic            m_tvalid,
    output logic            m_tlast,
    output fifo_pkg::user_t m_tuser
);

    localparam int LAST_STAGE = PIPELINE_OUTPUT - 1;

    fifo_pkg::word_t            pipe_word [PIPELINE_OUTPUT];
    logic [PIPELINE_OUTPUT-1:0] pipe_valid;
    logic [PIPELINE_OUTPUT-1:0] advance;

    // a stage moves when output drains or any later stage holds a bubble
    always_comb begin
        for (int j = 0; j < PIPELINE_OUTPUT; j++) begin
            advance[j] = m_tready || (|(~pipe_valid >> j));
        end
    end

    assign accept = advance[0];

    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            pipe_valid <= '0;
        end else begin
            for (int j = LAST_STAGE; j > 0; j--) begin
                if (advance[j]) begin
                    pipe_valid[j] <= pipe_valid[j-1];
                end
            end
            // stage 0 fills only when the read side had data
            if (advance[0]) begin
                pipe_valid[0] <= pop;
            end
        end
    end

    always_ff @(posedge m_clk) begin
        for (int j = LAST_STAGE; j > 0; j--) begin
            if (advance[j]) begin
                pipe_word[j] <= pipe_word[j-1];
            end
        end
        if (advance[0]) begin
            pipe_word[0] <= rd_word;
        end
    end

    // unpack last stage
    assign m_tvalid = pipe_valid[LAST_STAGE];
    assign m_tdata  = pipe_word[LAST_STAGE][fifo_pkg::DATA_WIDTH-1:0];
    assign m_tlast  = pipe_word[LAST_STAGE][fifo_pkg::LAST_POS];
    assign m_tuser  = pipe_word[LAST_STAGE][fifo_pkg::USER_POS +: fifo_pkg::USER_WIDTH];

endmodule

//--- fifo_mem.sv
// contents are undefined after power-up; read is asynchronous to the write clock
`timescale 1ns/1ps

module fifo_mem #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  s_clk,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  fifo_pkg::word_t       wr_word,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output fifo_pkg::word_t       rd_word
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    fifo_pkg::word_t mem [DEPTH];

    always_ff @(posedge s_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // read side registers this in the first pipeline stage
    assign rd_word = mem[rd_addr];

endmodule

//--- fifo_read_ctrl.sv
// pop is combinational from accept; the FIFO only reads as empty after a pointer sync delay
`timescale 1ns/1ps

module fifo_read_ctrl #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  m_clk,
    input  logic                  m_rst,
    input  logic                  accept,
    input  logic [ADDR_WIDTH:0]   wr_ptr_gray,
    output logic                  pop,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [ADDR_WIDTH:0]   rd_ptr_gray
);

    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_next;
    fifo_pkg::ptr_wide_t rd_gray_wide;
    logic [ADDR_WIDTH:0] wr_gray_sync1;
    logic [ADDR_WIDTH:0] wr_gray_sync2;
    logic                empty;

    assign rd_ptr_next  = rd_ptr + 1'b1;
    assign rd_gray_wide = fifo_pkg::bin_to_gray(fifo_pkg::ptr_wide_t'(rd_ptr_next));

    // empty when the gray pointers match exactly
    assign empty   = (rd_ptr_gray == wr_gray_sync2);
    assign pop     = accept && !empty;
    assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else if (pop) begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= rd_gray_wide[ADDR_WIDTH:0];
        end
    end

    // write pointer into the read domain
    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

endmodule

//--- fifo_write_ctrl.sv
// needs ADDR_WIDTH of 2 to 15; s_tready stays low while s_rst is high
`timescale 1ns/1ps

module fifo_write_ctrl #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  fifo_pkg::data_t       s_tdata,
    input  logic                  s_tvalid,
    input  logic                  s_tlast,
    input  fifo_pkg::user_t       s_tuser,
    input  logic [ADDR_WIDTH:0]   rd_ptr_gray,
    output logic                  s_tready,
    output logic                  wr_en,
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output fifo_pkg::word_t       wr_word,
    output logic [ADDR_WIDTH:0]   wr_ptr_gray
);

    // full pattern: top two gray bits inverted, the rest equal
    localparam logic [ADDR_WIDTH:0] FULL_MASK = {2'b11, {(ADDR_WIDTH-1){1'b0}}};

    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_next;
    fifo_pkg::ptr_wide_t wr_gray_wide;
    logic [ADDR_WIDTH:0] rd_gray_sync1;
    logic [ADDR_WIDTH:0] rd_gray_sync2;
    logic                full;

    assign wr_ptr_next  = wr_ptr + 1'b1;
    assign wr_gray_wide = fifo_pkg::bin_to_gray(fifo_pkg::ptr_wide_t'(wr_ptr_next));

    assign full     = (wr_ptr_gray == (rd_gray_sync2 ^ FULL_MASK));
    assign s_tready = !full && !s_rst;
    assign wr_en    = s_tvalid && s_tready;

    // memory side of the write
    assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];
    assign wr_word = {s_tuser, s_tlast, s_tdata};

    // write pointer, binary and gray advance together
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_en) begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= wr_gray_wide[ADDR_WIDTH:0];
        end
    end

    // read pointer into the write domain, two flops
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

endmodule

//--- reset_sync.sv
// async_rst may be asserted at any time; each output releases on its own clock three edges later
`timescale 1ns/1ps

module reset_sync (
    input  logic async_rst,
    input  logic s_clk,
    input  logic m_clk,
    output logic s_rst,
    output logic m_rst
);

    logic s_rst_sync1;
    logic s_rst_sync2;
    logic s_rst_sync3;
    logic m_rst_sync1;
    logic m_rst_sync2;
    logic m_rst_sync3;

    // write domain chain
    // stage 2 waits for both first stages, so release needs both domains out of reset
    always_ff @(posedge s_clk or posedge async_rst) begin
        if (async_rst) begin
            s_rst_sync1 <= 1'b1;
            s_rst_sync2 <= 1'b1;
            s_rst_sync3 <= 1'b1;
        end else begin
            s_rst_sync1 <= 1'b0;
            s_rst_sync2 <= s_rst_sync1 || m_rst_sync1;
            s_rst_sync3 <= s_rst_sync2;
        end
    end

    // read domain chain, same structure
    always_ff @(posedge m_clk or posedge async_rst) begin
        if (async_rst) begin
            m_rst_sync1 <= 1'b1;
            m_rst_sync2 <= 1'b1;
            m_rst_sync3 <= 1'b1;
        end else begin
            m_rst_sync1 <= 1'b0;
            m_rst_sync2 <= s_rst_sync1 || m_rst_sync1;
            m_rst_sync3 <= m_rst_sync2;
        end
    end

    assign s_rst = s_rst_sync3;
    assign m_rst = m_rst_sync3;

endmodule

//--- fifo_pkg.sv
// field layout fixed at 8 data bits, 1 last bit and 1 user bit; pointers up to 16 bits wide
package fifo_pkg;

    // stream field widths
    localparam int DATA_WIDTH = 8;
    localparam int USER_WIDTH = 1;
    localparam int WORD_WIDTH = DATA_WIDTH + 1 + USER_WIDTH;

    // bit positions inside a stored word
    localparam int LAST_POS = DATA_WIDTH;
    localparam int USER_POS = DATA_WIDTH + 1;

    // widest pointer the gray helper handles (ADDR_WIDTH up to 15)
    localparam int PTR_MAX_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [USER_WIDTH-1:0] user_t;
    // user on top, then last, data in the low bits
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [PTR_MAX_WIDTH-1:0] ptr_wide_t;

    // binary to gray, caller zero-extends the input and keeps the low bits
    function automatic ptr_wide_t bin_to_gray(input ptr_wide_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage
